// File: rv_core_alu.sv
// integer and multiply/divide alu
`timescale 1ns/1ns

module rv_core_alu (
  input  rv_core_pkg::ctrl_t i_ctrl,
  input  rv_core_pkg::xlen_t i_rs1,
  input  rv_core_pkg::xlen_t i_rs2,
  input  rv_core_pkg::xlen_t i_pc,
  output rv_core_pkg::xlen_t o_result,
  output logic               o_zero,
  output logic               o_less
);
  import rv_core_pkg::*;

  xlen_t      src_a, src_b;
  xlen_t      op_a, op_b;
  xlen_t      sx_a, sx_b;
  xlen_t      res;
  logic [5:0] shamt;
  logic       lt, ltu;
  logic       div_zero, div_ovf;

  assign src_a = (i_ctrl.a_sel == A_PC) ? i_pc : i_rs1;

  always_comb begin
    case (i_ctrl.b_sel)
      B_RS2:   src_b = i_rs2;
      B_IMM:   src_b = i_ctrl.imm;
      default: src_b = 64'd4;
    endcase
  end

  // word cut zero-extends, signed ops need the sign-extended copy
  assign op_a = i_ctrl.word_cut ? {32'b0, src_a[31:0]} : src_a;
  assign op_b = i_ctrl.word_cut ? {32'b0, src_b[31:0]} : src_b;
  assign sx_a = i_ctrl.word_cut ? {{32{src_a[31]}}, src_a[31:0]} : src_a;
  assign sx_b = i_ctrl.word_cut ? {{32{src_b[31]}}, src_b[31:0]} : src_b;

  assign shamt = i_ctrl.word_cut ? {1'b0, op_b[4:0]} : op_b[5:0];

  assign lt  = $signed(op_a) < $signed(op_b);
  assign ltu = op_a < op_b;

  assign div_zero = op_b == '0;
  assign div_ovf  = (sx_a == {1'b1, 63'b0}) && (sx_b == '1);

  always_comb begin
    case (i_ctrl.alu_op)
      ALU_COPY: res = i_ctrl.imm;
      ALU_ADD:  res = op_a + op_b;
      ALU_SUB:  res = op_a - op_b;
      ALU_SLT:  res = {63'b0, lt};
      ALU_SLTU: res = {63'b0, ltu};
      ALU_XOR:  res = op_a ^ op_b;
      ALU_AND:  res = op_a & op_b;
      ALU_OR:   res = op_a | op_b;
      ALU_SLL:  res = op_a << shamt;
      ALU_SRL:  res = op_a >> shamt;
      ALU_SRA:  res = $signed(sx_a) >>> shamt;
      ALU_MUL:  res = op_a * op_b;
      ALU_DIV: begin
        if (div_zero) begin
          res = '1;
        end else if (div_ovf) begin
          res = sx_a;
        end else begin
          res = $signed(sx_a) / $signed(sx_b);
        end
      end
      ALU_DIVU: res = div_zero ? '1 : op_a / op_b;
      ALU_REM: begin
        if (div_zero) begin
          res = sx_a;
        end else if (div_ovf) begin
          res = '0;
        end else begin
          res = $signed(sx_a) % $signed(sx_b);
        end
      end
      ALU_REMU: res = div_zero ? op_a : op_a % op_b;
      default:  res = '0;
    endcase
  end

  assign o_result = i_ctrl.word_cut ? {{32{res[31]}}, res[31:0]} : res;
  assign o_zero   = o_result == '0;
  assign o_less   = (i_ctrl.alu_op == ALU_SLTU) ? ltu : lt;

endmodule

// File: rv_core_asserts.sv
// core protocol assertions
`timescale 1ns/1ns

module rv_core_asserts (
  input logic               i_clk,
  input logic               i_rst_n,
  input logic               o_dmem_we,
  input logic               o_dmem_re,
  input logic               o_halted,
  input logic               o_trapped,
  input rv_core_pkg::xlen_t o_pc
);
  import rv_core_pkg::*;

  // read by the testbench at the end of the run
  int fail_count = 0;

  a_we_re_excl: assert property (
    @(posedge i_clk) disable iff (!i_rst_n) !(o_dmem_we && o_dmem_re)
  ) else begin
    fail_count++;
    $error("data memory read and write strobes high together");
  end

  a_no_store_stopped: assert property (
    @(posedge i_clk) disable iff (!i_rst_n) (o_halted || o_trapped) |-> !o_dmem_we
  ) else begin
    fail_count++;
    $error("store strobe high while halted or trapped");
  end

  // pc frozen once halted
  a_pc_hold: assert property (
    @(posedge i_clk) disable iff (!i_rst_n) (o_halted && $past(o_halted)) |-> $stable(o_pc)
  ) else begin
    fail_count++;
    $error("pc moved while halted");
  end

  a_one_stop_state: assert property (
    @(posedge i_clk) disable iff (!i_rst_n) !(o_halted && o_trapped)
  ) else begin
    fail_count++;
    $error("halted and trapped both high");
  end

endmodule

bind rv_core_top rv_core_asserts asserts_i (.*);

// File: rv_core_decoder.sv
// instruction decode and run state
`timescale 1ns/1ns

module rv_core_decoder (
  input  logic               i_clk,
  input  logic               i_rst_n,
  input  rv_core_pkg::inst_t i_inst,
  output rv_core_pkg::ctrl_t o_ctrl,
  output logic               o_retire,
  output logic               o_halted,
  output logic               o_trapped
);
  import rv_core_pkg::*;

  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_IMM    = 7'b0010011;
  localparam logic [6:0] OPC_IMM32  = 7'b0011011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP32   = 7'b0111011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;
  localparam inst_t      INST_EBREAK = 32'h0010_0073;

  core_state_e state;
  ctrl_t       ctrl;
  logic        illegal;
  logic        ebreak;
  logic [6:0]  opcode;
  logic [6:0]  funct7;
  logic [2:0]  funct3;
  xlen_t       imm_i, imm_s, imm_b, imm_u, imm_j;

  function automatic alu_op_e int_op(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  int_op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  int_op = ALU_SLL;
      3'b010:  int_op = ALU_SLT;
      3'b011:  int_op = ALU_SLTU;
      3'b100:  int_op = ALU_XOR;
      3'b101:  int_op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  int_op = ALU_OR;
      default: int_op = ALU_AND;
    endcase
  endfunction

  // mulh variants are not in the op set and decode as illegal
  function automatic alu_op_e mul_op(input logic [2:0] f3);
    case (f3)
      3'b100:  mul_op = ALU_DIV;
      3'b101:  mul_op = ALU_DIVU;
      3'b110:  mul_op = ALU_REM;
      3'b111:  mul_op = ALU_REMU;
      default: mul_op = ALU_MUL;
    endcase
  endfunction

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{51{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{43{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  always_comb begin
    ctrl.alu_op     = ALU_ADD;
    ctrl.a_sel      = A_RS1;
    ctrl.b_sel      = B_IMM;
    ctrl.word_cut   = 1'b0;
    ctrl.branch     = BR_NONE;
    ctrl.mem_re     = 1'b0;
    ctrl.mem_we     = 1'b0;
    ctrl.mem_op     = MEM_D;
    ctrl.mem_to_reg = 1'b0;
    ctrl.reg_we     = 1'b0;
    ctrl.rd         = i_inst[11:7];
    ctrl.imm        = imm_i;
    illegal         = 1'b0;
    ebreak          = 1'b0;
    case (opcode)
      OPC_LUI: begin
        ctrl.alu_op = ALU_COPY;
        ctrl.imm    = imm_u;
        ctrl.reg_we = 1'b1;
      end
      OPC_AUIPC: begin
        ctrl.a_sel  = A_PC;
        ctrl.imm    = imm_u;
        ctrl.reg_we = 1'b1;
      end
      // link value pc + 4 comes out of the alu
      OPC_JAL, OPC_JALR: begin
        ctrl.a_sel  = A_PC;
        ctrl.b_sel  = B_FOUR;
        ctrl.reg_we = 1'b1;
        ctrl.branch = (opcode == OPC_JAL) ? BR_JAL : BR_JALR;
        ctrl.imm    = (opcode == OPC_JAL) ? imm_j : imm_i;
        illegal     = (opcode == OPC_JALR) && (funct3 != 3'b000);
      end
      OPC_BRANCH: begin
        ctrl.b_sel = B_RS2;
        ctrl.imm   = imm_b;
        case (funct3)
          3'b000:  ctrl.branch = BR_BEQ;
          3'b001:  ctrl.branch = BR_BNE;
          3'b100:  ctrl.branch = BR_BLT;
          3'b101:  ctrl.branch = BR_BGE;
          3'b110:  ctrl.branch = BR_BLTU;
          3'b111:  ctrl.branch = BR_BGEU;
          default: illegal = 1'b1;
        endcase
        ctrl.alu_op = funct3[2] ? (funct3[1] ? ALU_SLTU : ALU_SLT) : ALU_SUB;
      end
      OPC_LOAD: begin
        ctrl.mem_re     = 1'b1;
        ctrl.mem_to_reg = 1'b1;
        ctrl.reg_we     = 1'b1;
        case (funct3)
          3'b000:  ctrl.mem_op = MEM_B;
          3'b001:  ctrl.mem_op = MEM_H;
          3'b010:  ctrl.mem_op = MEM_W;
          3'b011:  ctrl.mem_op = MEM_D;
          3'b100:  ctrl.mem_op = MEM_BU;
          3'b101:  ctrl.mem_op = MEM_HU;
          3'b110:  ctrl.mem_op = MEM_WU;
          default: illegal = 1'b1;
        endcase
      end
      OPC_STORE: begin
        ctrl.mem_we = 1'b1;
        ctrl.imm    = imm_s;
        case (funct3)
          3'b000:  ctrl.mem_op = MEM_B;
          3'b001:  ctrl.mem_op = MEM_H;
          3'b010:  ctrl.mem_op = MEM_W;
          3'b011:  ctrl.mem_op = MEM_D;
          default: illegal = 1'b1;
        endcase
      end
      OPC_IMM: begin
        ctrl.reg_we = 1'b1;
        ctrl.alu_op = int_op(funct3, (funct3 == 3'b101) && i_inst[30]);
        if (funct3 == 3'b001) begin
          illegal = i_inst[31:26] != 6'b000000;
        end else if (funct3 == 3'b101) begin
          illegal = (i_inst[31:26] != 6'b000000) && (i_inst[31:26] != 6'b010000);
        end
      end
      OPC_IMM32: begin
        ctrl.reg_we   = 1'b1;
        ctrl.word_cut = 1'b1;
        ctrl.alu_op   = int_op(funct3, (funct3 == 3'b101) && i_inst[30]);
        case (funct3)
          3'b000:  illegal = 1'b0;
          3'b001:  illegal = funct7 != 7'b0000000;
          3'b101:  illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
          default: illegal = 1'b1;
        endcase
      end
      OPC_OP, OPC_OP32: begin
        ctrl.b_sel    = B_RS2;
        ctrl.reg_we   = 1'b1;
        ctrl.word_cut = opcode == OPC_OP32;
        if (funct7 == 7'b0000001) begin
          ctrl.alu_op = mul_op(funct3);
          illegal     = (funct3 != 3'b000) && !funct3[2];
        end else begin
          ctrl.alu_op = int_op(funct3, funct7[5]);
          if (funct7 == 7'b0100000) begin
            illegal = (funct3 != 3'b000) && (funct3 != 3'b101);
          end else if (funct7 != 7'b0000000) begin
            illegal = 1'b1;
          end else if (opcode == OPC_OP32) begin
            illegal = (funct3 != 3'b000) && (funct3 != 3'b001) && (funct3 != 3'b101);
          end
        end
      end
      OPC_SYSTEM: begin
        ebreak  = i_inst == INST_EBREAK;
        illegal = i_inst != INST_EBREAK;
      end
      default: illegal = 1'b1;
    endcase
    // ebreak and illegal instructions leave no trace
    if (illegal || ebreak) begin
      ctrl.branch = BR_NONE;
      ctrl.mem_re = 1'b0;
      ctrl.mem_we = 1'b0;
      ctrl.reg_we = 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      state <= RUN;
    end else if (state == RUN) begin
      if (illegal) begin
        state <= TRAP;
      end else if (ebreak) begin
        state <= HALT;
      end
    end
  end

  assign o_ctrl    = ctrl;
  assign o_retire  = state == RUN;
  assign o_halted  = state == HALT;
  assign o_trapped = state == TRAP;

endmodule

// File: rv_core_lsu.sv
// load/store lanes and write-back select
`timescale 1ns/1ns

module rv_core_lsu (
  input  rv_core_pkg::ctrl_t i_ctrl,
  input  logic               i_retire,
  input  rv_core_pkg::xlen_t i_addr,
  input  rv_core_pkg::xlen_t i_rs2,
  input  rv_core_pkg::xlen_t i_rdata,
  input  rv_core_pkg::xlen_t i_alu_result,
  output rv_core_pkg::xlen_t o_dmem_addr,
  output rv_core_pkg::xlen_t o_dmem_wdata,
  output logic               o_dmem_we,
  output logic [7:0]         o_dmem_wmask,
  output logic               o_dmem_re,
  output rv_core_pkg::xlen_t o_wb_data
);
  import rv_core_pkg::*;

  logic [2:0] off;
  xlen_t      lane_h, lane_w;
  logic [7:0] lane_b;
  xlen_t      load_data;

  assign off = i_addr[2:0];

  // low offset bits below the access size are ignored
  always_comb begin
    case (i_ctrl.mem_op)
      MEM_B, MEM_BU: begin
        o_dmem_wdata = {8{i_rs2[7:0]}};
        o_dmem_wmask = 8'h01 << off;
      end
      MEM_H, MEM_HU: begin
        o_dmem_wdata = {4{i_rs2[15:0]}};
        o_dmem_wmask = 8'h03 << {off[2:1], 1'b0};
      end
      MEM_W, MEM_WU: begin
        o_dmem_wdata = {2{i_rs2[31:0]}};
        o_dmem_wmask = 8'h0f << {off[2], 2'b00};
      end
      default: begin
        o_dmem_wdata = i_rs2;
        o_dmem_wmask = 8'hff;
      end
    endcase
  end

  assign lane_b = i_rdata[{off, 3'b000} +: 8];
  assign lane_h = i_rdata >> {off[2:1], 4'b0000};
  assign lane_w = i_rdata >> {off[2], 5'b00000};

  always_comb begin
    case (i_ctrl.mem_op)
      MEM_B:   load_data = {{56{lane_b[7]}}, lane_b};
      MEM_BU:  load_data = {56'b0, lane_b};
      MEM_H:   load_data = {{48{lane_h[15]}}, lane_h[15:0]};
      MEM_HU:  load_data = {48'b0, lane_h[15:0]};
      MEM_W:   load_data = {{32{lane_w[31]}}, lane_w[31:0]};
      MEM_WU:  load_data = {32'b0, lane_w[31:0]};
      default: load_data = i_rdata;
    endcase
  end

  assign o_dmem_addr = i_addr;
  assign o_dmem_we   = i_ctrl.mem_we && i_retire;
  assign o_dmem_re   = i_ctrl.mem_re;
  assign o_wb_data   = i_ctrl.mem_to_reg ? load_data : i_alu_result;

endmodule

// File: rv_core_pc.sv
// program counter
`timescale 1ns/1ns

module rv_core_pc #(
  parameter rv_core_pkg::xlen_t RESET_PC = '0
) (
  input  logic               i_clk,
  input  logic               i_rst_n,
  input  rv_core_pkg::ctrl_t i_ctrl,
  input  rv_core_pkg::xlen_t i_rs1,
  input  logic               i_zero,
  input  logic               i_less,
  input  logic               i_retire,
  output rv_core_pkg::xlen_t o_pc
);
  import rv_core_pkg::*;

  xlen_t pc;
  xlen_t base;
  xlen_t next_pc;
  logic  take;

  always_comb begin
    case (i_ctrl.branch)
      BR_JAL, BR_JALR:   take = 1'b1;
      BR_BEQ:            take = i_zero;
      BR_BNE:            take = !i_zero;
      BR_BLT, BR_BLTU:   take = i_less;
      BR_BGE, BR_BGEU:   take = !i_less;
      default:           take = 1'b0;
    endcase
  end

  assign base = (i_ctrl.branch == BR_JALR) ? i_rs1 : pc;

  always_comb begin
    next_pc = base + (take ? i_ctrl.imm : 64'd4);
    // jalr target has bit 0 cleared
    if (i_ctrl.branch == BR_JALR) begin
      next_pc[0] = 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      pc <= RESET_PC;
    end else if (i_retire) begin
      pc <= next_pc;
    end
  end

  assign o_pc = pc;

endmodule

// File: rv_core_pkg.sv
// rv64im core shared types
package rv_core_pkg;

  typedef logic [63:0] xlen_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_idx_t;

  // alu control codes
  typedef enum logic [4:0] {
    ALU_COPY = 5'b00011,
    ALU_ADD  = 5'b00000,
    ALU_SUB  = 5'b01000,
    ALU_SLT  = 5'b00010,
    ALU_SLTU = 5'b01010,
    ALU_XOR  = 5'b00100,
    ALU_AND  = 5'b00111,
    ALU_OR   = 5'b00110,
    ALU_SLL  = 5'b00001,
    ALU_SRL  = 5'b00101,
    ALU_SRA  = 5'b01101,
    ALU_MUL  = 5'b11100,
    ALU_DIV  = 5'b11011,
    ALU_DIVU = 5'b11010,
    ALU_REM  = 5'b11101,
    ALU_REMU = 5'b11001
  } alu_op_e;

  typedef enum logic {
    A_RS1 = 1'b0,
    A_PC  = 1'b1
  } alu_a_sel_e;

  typedef enum logic [1:0] {
    B_RS2  = 2'b00,
    B_IMM  = 2'b01,
    B_FOUR = 2'b10
  } alu_b_sel_e;

  // unsigned compares share the signed codes with bit 3 set
  typedef enum logic [3:0] {
    BR_NONE = 4'b0000,
    BR_JAL  = 4'b0001,
    BR_JALR = 4'b0010,
    BR_BEQ  = 4'b0100,
    BR_BNE  = 4'b0101,
    BR_BLT  = 4'b0110,
    BR_BGE  = 4'b0111,
    BR_BLTU = 4'b1110,
    BR_BGEU = 4'b1111
  } branch_op_e;

  typedef enum logic [2:0] {
    MEM_B  = 3'b000,
    MEM_BU = 3'b001,
    MEM_H  = 3'b010,
    MEM_HU = 3'b011,
    MEM_W  = 3'b100,
    MEM_WU = 3'b101,
    MEM_D  = 3'b110
  } mem_op_e;

  typedef enum logic [1:0] {
    RUN  = 2'b00,
    HALT = 2'b01,
    TRAP = 2'b10
  } core_state_e;

  typedef struct packed {
    alu_op_e    alu_op;
    alu_a_sel_e a_sel;
    alu_b_sel_e b_sel;
    logic       word_cut;
    branch_op_e branch;
    logic       mem_re;
    logic       mem_we;
    mem_op_e    mem_op;
    logic       mem_to_reg;
    logic       reg_we;
    reg_idx_t   rd;
    xlen_t      imm;
  } ctrl_t;

endpackage

// File: rv_core_regfile.sv
// integer register file
`timescale 1ns/1ns

module rv_core_regfile (
  input  logic                  i_clk,
  input  rv_core_pkg::reg_idx_t i_rs1_idx,
  input  rv_core_pkg::reg_idx_t i_rs2_idx,
  input  rv_core_pkg::reg_idx_t i_rd_idx,
  input  logic                  i_we,
  input  rv_core_pkg::xlen_t    i_wdata,
  output rv_core_pkg::xlen_t    o_rs1,
  output rv_core_pkg::xlen_t    o_rs2
);
  import rv_core_pkg::*;

  // x0 has no storage
  xlen_t regs [1:31];

  always_ff @(posedge i_clk) begin
    if (i_we && (i_rd_idx != 5'd0)) begin
      regs[i_rd_idx] <= i_wdata;
    end
  end

  assign o_rs1 = (i_rs1_idx == 5'd0) ? '0 : regs[i_rs1_idx];
  assign o_rs2 = (i_rs2_idx == 5'd0) ? '0 : regs[i_rs2_idx];

endmodule

// File: rv_core_top.f
rv_core_pkg.sv
rv_core_decoder.sv
rv_core_pc.sv
rv_core_regfile.sv
rv_core_alu.sv
rv_core_lsu.sv
rv_core_top.sv
rv_core_asserts.sv
tb_rv_core.sv

// File: rv_core_top.sv
// rv64im single-cycle core
`timescale 1ns/1ns

module rv_core_top #(
  parameter rv_core_pkg::xlen_t RESET_PC = '0
) (
  input  logic               i_clk,
  input  logic               i_rst_n,
  input  rv_core_pkg::inst_t i_inst,
  input  rv_core_pkg::xlen_t i_dmem_rdata,
  output rv_core_pkg::xlen_t o_pc,
  output rv_core_pkg::xlen_t o_dmem_addr,
  output rv_core_pkg::xlen_t o_dmem_wdata,
  output logic               o_dmem_we,
  output logic [7:0]         o_dmem_wmask,
  output logic               o_dmem_re,
  output logic               o_halted,
  output logic               o_trapped
);
  import rv_core_pkg::*;

  ctrl_t ctrl;
  logic  retire;
  xlen_t rs1, rs2;
  xlen_t alu_result;
  xlen_t wb_data;
  logic  zero, less;

  rv_core_decoder decoder_i (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_inst    (i_inst),
    .o_ctrl    (ctrl),
    .o_retire  (retire),
    .o_halted  (o_halted),
    .o_trapped (o_trapped)
  );

  rv_core_pc #(
    .RESET_PC (RESET_PC)
  ) pc_i (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_ctrl   (ctrl),
    .i_rs1    (rs1),
    .i_zero   (zero),
    .i_less   (less),
    .i_retire (retire),
    .o_pc     (o_pc)
  );

  // register write only on a retiring instruction
  rv_core_regfile regfile_i (
    .i_clk     (i_clk),
    .i_rs1_idx (i_inst[19:15]),
    .i_rs2_idx (i_inst[24:20]),
    .i_rd_idx  (ctrl.rd),
    .i_we      (ctrl.reg_we && retire),
    .i_wdata   (wb_data),
    .o_rs1     (rs1),
    .o_rs2     (rs2)
  );

  rv_core_alu alu_i (
    .i_ctrl   (ctrl),
    .i_rs1    (rs1),
    .i_rs2    (rs2),
    .i_pc     (o_pc),
    .o_result (alu_result),
    .o_zero   (zero),
    .o_less   (less)
  );

  rv_core_lsu lsu_i (
    .i_ctrl       (ctrl),
    .i_retire     (retire),
    .i_addr       (alu_result),
    .i_rs2        (rs2),
    .i_rdata      (i_dmem_rdata),
    .i_alu_result (alu_result),
    .o_dmem_addr  (o_dmem_addr),
    .o_dmem_wdata (o_dmem_wdata),
    .o_dmem_we    (o_dmem_we),
    .o_dmem_wmask (o_dmem_wmask),
    .o_dmem_re    (o_dmem_re),
    .o_wb_data    (wb_data)
  );

endmodule

// File: tb_rv_core.sv
// rv64im core testbench
`timescale 1ns/1ns

module tb_rv_core;
  import rv_core_pkg::*;

  localparam xlen_t      RESET_PC  = '0;
  localparam int         IMEM_SIZE = 512;
  localparam logic [6:0] OPC_LOAD  = 7'b0000011;
  localparam logic [6:0] OPC_STORE = 7'b0100011;
  localparam logic [6:0] OPC_IMM   = 7'b0010011;
  localparam logic [6:0] OPC_OP    = 7'b0110011;
  localparam logic [6:0] OPC_OP32  = 7'b0111011;
  localparam int K_ADD = 0, K_SUB = 1, K_SLT = 2, K_SLTU = 3, K_XOR = 4, K_AND = 5;
  localparam int K_OR = 6, K_SLL = 7, K_SRL = 8, K_SRA = 9, K_MUL = 10, K_DIV = 11;
  localparam int K_DIVU = 12, K_REM = 13, K_REMU = 14;
  localparam xlen_t MIN64 = {1'b1, 63'b0};

  typedef struct packed {
    xlen_t      addr;
    logic [7:0] mask;
    xlen_t      data;
  } store_t;

  logic       clk;
  logic       rst_n;
  inst_t      inst;
  xlen_t      dmem_rdata;
  xlen_t      pc, dmem_addr, dmem_wdata;
  logic       dmem_we, dmem_re, halted, trapped;
  logic [7:0] dmem_wmask;

  inst_t  prog [2][IMEM_SIZE];
  int     plen [2];
  int     bld, run;
  xlen_t  dmem [256];
  store_t exp_q[$];
  int     errors, cycles, limit;
  xlen_t  st_addr, va, vb, vc;

  rv_core_top #(
    .RESET_PC (RESET_PC)
  ) rv_core_top_i (
    .i_clk        (clk),
    .i_rst_n      (rst_n),
    .i_inst       (inst),
    .i_dmem_rdata (dmem_rdata),
    .o_pc         (pc),
    .o_dmem_addr  (dmem_addr),
    .o_dmem_wdata (dmem_wdata),
    .o_dmem_we    (dmem_we),
    .o_dmem_wmask (dmem_wmask),
    .o_dmem_re    (dmem_re),
    .o_halted     (halted),
    .o_trapped    (trapped)
  );

  always #4 clk = ~clk;

  // both memories answer in the same cycle
  assign inst       = prog[run][pc[10:2]];
  assign dmem_rdata = dmem[dmem_addr[10:3]];

  always @(posedge clk) begin : store_monitor
    store_t e;
    xlen_t  bm;
    for (int i = 0; i < 8; i++) begin
      bm[8*i +: 8] = {8{dmem_wmask[i]}};
    end
    if (rst_n && dmem_we) begin
      for (int i = 0; i < 8; i++) begin
        if (dmem_wmask[i]) begin
          dmem[dmem_addr[10:3]][8*i +: 8] <= dmem_wdata[8*i +: 8];
        end
      end
      if (exp_q.size() == 0) begin
        errors++;
        $display("unexpected store to address %h at %0t", dmem_addr, $time);
      end else begin
        e = exp_q.pop_front();
        assert (dmem_addr == e.addr && dmem_wmask == e.mask &&
                (dmem_wdata & bm) == (e.data & bm)) else begin
          errors++;
          $display("** Error at %0t: store to %h mask %h expected %h, got %h at %h mask %h",
                   $time, e.addr, e.mask, e.data, dmem_wdata, dmem_addr, dmem_wmask);
        end
      end
    end
  end

  // read strobe follows the load opcode while running
  always @(posedge clk) begin
    if (rst_n && !halted && !trapped) begin
      assert (dmem_re == (inst[6:0] == OPC_LOAD)) else begin
        errors++;
        $display("** Error at %0t: read strobe %b for instruction %h at pc %h",
                 $time, dmem_re, inst, pc);
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= limit) begin
      $display("timeout: core did not halt or trap within %0d cycles", limit);
      $display("errors: %0d", errors + 1);
      $display("test failed");
      $finish;
    end
  end

  function automatic inst_t r_type(input logic [6:0] f7, input int rs2, input int rs1,
                                   input int f3, input int rd, input logic [6:0] op);
    return {f7, 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), op};
  endfunction

  function automatic inst_t i_type(input logic [11:0] imm, input int rs1, input int f3,
                                   input int rd, input logic [6:0] op);
    return {imm, 5'(rs1), 3'(f3), 5'(rd), op};
  endfunction

  function automatic inst_t s_type(input logic [11:0] imm, input int rs2, input int rs1,
                                   input int f3);
    return {imm[11:5], 5'(rs2), 5'(rs1), 3'(f3), imm[4:0], OPC_STORE};
  endfunction

  function automatic inst_t b_type(input logic [12:0] imm, input int rs2, input int rs1,
                                   input int f3);
    return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), 3'(f3), imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic inst_t j_type(input logic [20:0] imm, input int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), 7'b1101111};
  endfunction

  function automatic xlen_t cur_pc();
    return RESET_PC + 4 * plen[bld];
  endfunction

  // expected result from the isa rules
  function automatic xlen_t ref_calc(input int k, input xlen_t a, input xlen_t b,
                                     input bit w);
    xlen_t x, y, sx, sy, r;
    int    sh;
    x  = w ? {32'b0, a[31:0]} : a;
    y  = w ? {32'b0, b[31:0]} : b;
    sx = w ? {{32{a[31]}}, a[31:0]} : a;
    sy = w ? {{32{b[31]}}, b[31:0]} : b;
    sh = w ? int'(b[4:0]) : int'(b[5:0]);
    case (k)
      K_ADD:   r = x + y;
      K_SUB:   r = x - y;
      K_SLT:   r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
      K_SLTU:  r = (a < b) ? 64'd1 : 64'd0;
      K_XOR:   r = x ^ y;
      K_AND:   r = x & y;
      K_OR:    r = x | y;
      K_SLL:   r = x << sh;
      K_SRL:   r = x >> sh;
      K_SRA:   r = $signed(sx) >>> sh;
      K_MUL:   r = x * y;
      K_DIV: begin
        if (sy == 0) begin
          r = '1;
        end else if (sx == MIN64 && sy == '1) begin
          r = sx;
        end else begin
          r = $signed(sx) / $signed(sy);
        end
      end
      K_DIVU:  r = (y == 0) ? '1 : x / y;
      K_REM: begin
        if (sy == 0) begin
          r = sx;
        end else if (sx == MIN64 && sy == '1) begin
          r = '0;
        end else begin
          r = $signed(sx) % $signed(sy);
        end
      end
      default: r = (y == 0) ? x : x % y;
    endcase
    return w ? {{32{r[31]}}, r[31:0]} : r;
  endfunction

  task automatic emit(input inst_t i);
    prog[bld][plen[bld]] = i;
    plen[bld]++;
  endtask

  task automatic emit_sd(input int rs, input xlen_t addr, input xlen_t val, input bit expected);
    emit(s_type(addr[11:0], rs, 0, 3));
    if (expected) begin
      exp_q.push_back('{addr: addr, mask: 8'hff, data: val});
    end
  endtask

  task automatic store_check(input int rs, input xlen_t val);
    emit_sd(rs, st_addr, val, 1'b1);
    st_addr += 8;
  endtask

  task automatic alu_case(input logic [6:0] f7, input int f3, input int k, input bit w);
    emit(r_type(f7, 2, 1, f3, 3, w ? OPC_OP32 : OPC_OP));
    store_check(3, ref_calc(k, va, vb, w));
  endtask

  task automatic load_case(input int f3, input int off);
    xlen_t lane, v;
    lane = vc >> (8 * off);
    case (f3)
      0:       v = {{56{lane[7]}}, lane[7:0]};
      4:       v = {56'b0, lane[7:0]};
      1:       v = {{48{lane[15]}}, lane[15:0]};
      5:       v = {48'b0, lane[15:0]};
      2:       v = {{32{lane[31]}}, lane[31:0]};
      6:       v = {32'b0, lane[31:0]};
      default: v = vc;
    endcase
    emit(i_type(12'(32 + off), 0, f3, 3, OPC_LOAD));
    store_check(3, v);
  endtask

  task automatic lane_store(input int f3, input int off);
    logic [7:0] m;
    m = ((1 << (1 << f3)) - 1) << off;
    emit(s_type(12'(1536 + off), 1, 0, f3));
    exp_q.push_back('{addr: 1536 + off, mask: m, data: va << (8 * off)});
  endtask

  task automatic branch_case(input int f3, input int r1, input int r2, input xlen_t a,
                             input xlen_t b);
    bit taken;
    case (f3)
      0:       taken = a == b;
      1:       taken = a != b;
      4:       taken = $signed(a) < $signed(b);
      5:       taken = $signed(a) >= $signed(b);
      6:       taken = a < b;
      default: taken = a >= b;
    endcase
    emit(b_type(13'd8, r2, r1, f3));
    emit_sd(5, st_addr, 64'd111, !taken);
    st_addr += 8;
    store_check(6, 64'd222);
  endtask

  task automatic build_main();
    logic [19:0] uimm;
    xlen_t       p;
    int          f3s [6] = '{0, 1, 4, 5, 6, 7};
    bld = 0;
    st_addr = 512;
    emit(i_type(0, 0, 3, 1, OPC_LOAD));
    emit(i_type(8, 0, 3, 2, OPC_LOAD));
    emit(i_type(111, 0, 0, 5, OPC_IMM));
    emit(i_type(222, 0, 0, 6, OPC_IMM));
    alu_case(7'h00, 0, K_ADD, 0);
    alu_case(7'h20, 0, K_SUB, 0);
    alu_case(7'h00, 1, K_SLL, 0);
    alu_case(7'h00, 2, K_SLT, 0);
    alu_case(7'h00, 3, K_SLTU, 0);
    alu_case(7'h00, 4, K_XOR, 0);
    alu_case(7'h00, 5, K_SRL, 0);
    alu_case(7'h20, 5, K_SRA, 0);
    alu_case(7'h00, 6, K_OR, 0);
    alu_case(7'h00, 7, K_AND, 0);
    alu_case(7'h01, 0, K_MUL, 0);
    alu_case(7'h01, 4, K_DIV, 0);
    alu_case(7'h01, 5, K_DIVU, 0);
    alu_case(7'h01, 6, K_REM, 0);
    alu_case(7'h01, 7, K_REMU, 0);
    alu_case(7'h00, 0, K_ADD, 1);
    alu_case(7'h20, 0, K_SUB, 1);
    alu_case(7'h00, 1, K_SLL, 1);
    alu_case(7'h00, 5, K_SRL, 1);
    alu_case(7'h20, 5, K_SRA, 1);
    alu_case(7'h01, 0, K_MUL, 1);
    alu_case(7'h01, 4, K_DIV, 1);
    alu_case(7'h01, 7, K_REMU, 1);
    // signed overflow, then divide by zero
    emit(i_type(16, 0, 3, 1, OPC_LOAD));
    emit(i_type(24, 0, 3, 2, OPC_LOAD));
    va = MIN64;
    vb = '1;
    alu_case(7'h01, 4, K_DIV, 0);
    alu_case(7'h01, 6, K_REM, 0);
    emit(i_type(0, 0, 0, 2, OPC_IMM));
    vb = '0;
    alu_case(7'h01, 4, K_DIV, 0);
    alu_case(7'h01, 5, K_DIVU, 0);
    alu_case(7'h01, 6, K_REM, 0);
    alu_case(7'h01, 7, K_REMU, 0);
    emit(i_type(0, 0, 3, 1, OPC_LOAD));
    emit(i_type(8, 0, 3, 2, OPC_LOAD));
    va = dmem[0];
    vb = dmem[1];
    uimm = 20'($urandom) | 20'h80000;
    emit({uimm, 5'd3, 7'b0110111});
    store_check(3, {{32{uimm[19]}}, uimm, 12'b0});
    p = cur_pc();
    emit({uimm, 5'd3, 7'b0010111});
    store_check(3, p + {{32{uimm[19]}}, uimm, 12'b0});
    for (int f3 = 0; f3 < 7; f3++) begin
      for (int off = 0; off < 8; off += 1 << (f3 & 3)) begin
        load_case(f3, off);
      end
    end
    for (int f3 = 0; f3 < 4; f3++) begin
      for (int off = 0; off < 8; off += 1 << f3) begin
        lane_store(f3, off);
      end
    end
    foreach (f3s[i]) begin
      branch_case(f3s[i], 1, 2, va, vb);
      branch_case(f3s[i], 2, 1, vb, va);
      branch_case(f3s[i], 1, 1, va, va);
    end
    p = cur_pc();
    emit(j_type(21'd8, 7));
    emit_sd(6, st_addr, 0, 1'b0);
    store_check(7, p + 4);
    // jalr target odd by one, bit 0 cleared
    p = cur_pc();
    emit(i_type(12'(p + 12), 0, 0, 8, OPC_IMM));
    emit(i_type(1, 8, 0, 9, 7'b1100111));
    emit_sd(6, st_addr, 0, 1'b0);
    store_check(9, p + 8);
    emit(32'h0010_0073);
    emit_sd(6, st_addr, 0, 1'b0);
  endtask

  task automatic build_trap();
    bld = 1;
    emit(i_type(7, 0, 0, 3, OPC_IMM));
    // custom-0 opcode, would write x3 and is followed by a store
    emit(r_type(7'h00, 3, 3, 0, 3, 7'b0001011));
    emit_sd(3, 2000, 0, 1'b0);
  endtask

  task automatic run_prog(input int n);
    run = n;
    rst_n = 1'b0;
    repeat (2) @(negedge clk);
    assert (pc == RESET_PC && !dmem_we && !halted && !trapped) else begin
      errors++;
      $display("** Error at %0t: reset state pc %h we %b halted %b trapped %b",
               $time, pc, dmem_we, halted, trapped);
    end
    rst_n = 1'b1;
    while (!(halted || trapped)) begin
      @(negedge clk);
    end
    repeat (6) @(negedge clk);
  endtask

  initial begin
    void'($urandom(84));
    clk = 1'b0;
    rst_n = 1'b0;
    run = 0;
    errors = 0;
    cycles = 0;
    limit = 100000;
    for (int i = 0; i < IMEM_SIZE; i++) begin
      prog[0][i] = '0;
      prog[1][i] = '0;
    end
    for (int i = 0; i < 256; i++) begin
      dmem[i] = {~32'(i * 8), 32'(i * 8)};
    end
    plen[0] = 0;
    plen[1] = 0;
    va = {$urandom, $urandom};
    vb = {$urandom, $urandom};
    vc = {$urandom, $urandom};
    dmem[0] = va;
    dmem[1] = vb;
    dmem[2] = MIN64;
    dmem[3] = '1;
    dmem[4] = vc;
    build_main();
    build_trap();
    limit = 4 * (plen[0] + plen[1]) + 50;

    run_prog(0);
    assert (halted && !trapped) else begin
      errors++;
      $display("** Error at %0t: first run expected halt, halted %b trapped %b",
               $time, halted, trapped);
    end
    run_prog(1);
    assert (trapped && !halted) else begin
      errors++;
      $display("** Error at %0t: second run expected trap, halted %b trapped %b",
               $time, halted, trapped);
    end
    assert (rv_core_top_i.regfile_i.regs[3] == 64'd7) else begin
      errors++;
      $display("** Error at %0t: x3 expected %h, got %h", $time, 64'd7,
               rv_core_top_i.regfile_i.regs[3]);
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("%0d expected stores never happened", exp_q.size());
    end
    errors += rv_core_top_i.asserts_i.fail_count;
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule
